/* hw/rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] word_t;      // data and byte addresses
  typedef logic [4:0]  reg_addr_t;  // x0..x31

  // RV32I major opcodes
  localparam logic [6:0] OP_ALU    = 7'b0110011;
  localparam logic [6:0] OP_ALUI   = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ    // compares return 0 or 1
  } alu_op_e;

  typedef enum logic {
    A_REG,  // rs1
    A_PC
  } alu_a_e;

  typedef enum logic {
    B_REG,  // rs2
    B_IMM
  } alu_b_e;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_MEM,
    WB_PC_PLUS4
  } wb_src_e;

  typedef enum logic [1:0] {
    PC_NEXT,
    PC_ALU,     // jump target
    PC_BRANCH   // pc + imm when the compare holds
  } pc_src_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  typedef enum logic [1:0] {
    CU_FETCH,
    CU_EXEC,
    CU_WRITEBACK
  } cu_state_e;

endpackage

/* hw/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  y = a + b;
      rv_pkg::ALU_SUB:  y = a - b;
      rv_pkg::ALU_SLL:  y = a << shamt;
      rv_pkg::ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU: y = {31'b0, a < b};
      rv_pkg::ALU_XOR:  y = a ^ b;
      rv_pkg::ALU_SRL:  y = a >> shamt;
      rv_pkg::ALU_SRA:  y = $signed(a) >>> shamt;
      rv_pkg::ALU_OR:   y = a | b;
      rv_pkg::ALU_AND:  y = a & b;
      rv_pkg::ALU_EQ:   y = {31'b0, a == b};
      default:          y = '0;
    endcase
  end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t ra1,
  input  rv_pkg::reg_addr_t ra2,
  output rv_pkg::word_t     rd1,
  output rv_pkg::word_t     rd2,
  input  logic              we,
  input  rv_pkg::reg_addr_t wa,
  input  rv_pkg::word_t     wd
);

  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];  // x0 reads zero
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* hw/rv_control.sv */
`timescale 1ns/1ps

module rv_control (
  input  logic                clk,
  input  logic                rst,
  input  logic [6:0]          opcode,
  input  logic [2:0]          f3,
  input  logic [6:0]          f7,
  input  logic                mem_ack,
  input  logic                hold,
  output rv_pkg::cu_state_e   state,
  output rv_pkg::alu_a_e      alu_a,
  output rv_pkg::alu_b_e      alu_b,
  output rv_pkg::alu_op_e     alu_op,
  output logic                cmp_invert,
  output rv_pkg::imm_fmt_e    imm_fmt,
  output rv_pkg::wb_src_e     wb_src,
  output rv_pkg::pc_src_e     pc_src,
  output logic                mem_req,
  output logic                mem_we,
  output logic                load_ir,
  output logic                retire,
  output logic                fault
);

  logic            started;   // fetch cycle already on the bus
  logic            legal;
  logic            is_mem;
  logic            is_store;
  rv_pkg::alu_op_e arith_op;
  rv_pkg::alu_op_e cmp_op;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state   <= rv_pkg::CU_FETCH;
      started <= 1'b0;
      fault   <= 1'b0;
    end else begin
      started <= (state == rv_pkg::CU_FETCH) && mem_req && !mem_ack;
      case (state)
        rv_pkg::CU_FETCH: if (mem_ack) state <= rv_pkg::CU_EXEC;
        rv_pkg::CU_EXEC: begin
          if (!legal) fault <= 1'b1;  // parks here until reset
          else if (!mem_req || mem_ack) state <= rv_pkg::CU_WRITEBACK;
        end
        default: state <= rv_pkg::CU_FETCH;
      endcase
    end
  end

  // hold only takes effect before the fetch cycle has started
  assign mem_req = (state == rv_pkg::CU_FETCH) ? (started || !hold)
                                               : (state == rv_pkg::CU_EXEC && is_mem);
  assign mem_we  = (state == rv_pkg::CU_EXEC) && is_store;
  assign load_ir = (state == rv_pkg::CU_FETCH) && mem_ack;
  assign retire  = (state == rv_pkg::CU_WRITEBACK);

  always_comb begin
    case (f3)
      3'd0: arith_op = (opcode == rv_pkg::OP_ALU && f7[5]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'd1: arith_op = rv_pkg::ALU_SLL;
      3'd2: arith_op = rv_pkg::ALU_SLT;
      3'd3: arith_op = rv_pkg::ALU_SLTU;
      3'd4: arith_op = rv_pkg::ALU_XOR;
      3'd5: arith_op = f7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;  // srai too
      3'd6: arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
    case (f3[2:1])
      2'b10:   cmp_op = rv_pkg::ALU_SLT;
      2'b11:   cmp_op = rv_pkg::ALU_SLTU;
      default: cmp_op = rv_pkg::ALU_EQ;
    endcase
  end

  always_comb begin
    alu_a      = rv_pkg::A_REG;
    alu_b      = rv_pkg::B_REG;
    alu_op     = rv_pkg::ALU_ADD;
    cmp_invert = 1'b0;
    imm_fmt    = rv_pkg::IMM_I;
    wb_src     = rv_pkg::WB_NONE;
    pc_src     = rv_pkg::PC_NEXT;
    legal      = 1'b1;
    is_mem     = 1'b0;
    is_store   = 1'b0;
    case (opcode)
      rv_pkg::OP_ALU: begin
        alu_op = arith_op;
        wb_src = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_ALUI: begin
        alu_b  = rv_pkg::B_IMM;
        alu_op = arith_op;
        wb_src = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_LOAD: begin
        alu_b  = rv_pkg::B_IMM;
        wb_src = rv_pkg::WB_MEM;
        is_mem = 1'b1;
      end
      rv_pkg::OP_STORE: begin
        alu_b    = rv_pkg::B_IMM;
        imm_fmt  = rv_pkg::IMM_S;
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        alu_op     = cmp_op;
        cmp_invert = f3[0];  // bne, bge, bgeu
        imm_fmt    = rv_pkg::IMM_B;
        pc_src     = rv_pkg::PC_BRANCH;
      end
      rv_pkg::OP_JAL: begin
        alu_a   = rv_pkg::A_PC;
        alu_b   = rv_pkg::B_IMM;
        imm_fmt = rv_pkg::IMM_J;
        wb_src  = rv_pkg::WB_PC_PLUS4;
        pc_src  = rv_pkg::PC_ALU;
      end
      rv_pkg::OP_JALR: begin
        alu_b  = rv_pkg::B_IMM;
        wb_src = rv_pkg::WB_PC_PLUS4;
        pc_src = rv_pkg::PC_ALU;
      end
      rv_pkg::OP_LUI: begin
        alu_b   = rv_pkg::B_IMM;   // core reads x0 as operand a
        imm_fmt = rv_pkg::IMM_U;
        wb_src  = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_AUIPC: begin
        alu_a   = rv_pkg::A_PC;
        alu_b   = rv_pkg::B_IMM;
        imm_fmt = rv_pkg::IMM_U;
        wb_src  = rv_pkg::WB_ALU;
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  logic          hold,
  output logic          ibus_cyc,
  output logic          ibus_stb,
  output rv_pkg::word_t ibus_adr,
  input  rv_pkg::word_t ibus_dat_r,
  input  logic          ibus_ack,
  output logic          dbus_cyc,
  output logic          dbus_stb,
  output logic          dbus_we,
  output rv_pkg::word_t dbus_adr,
  output rv_pkg::word_t dbus_dat_w,
  input  rv_pkg::word_t dbus_dat_r,
  input  logic          dbus_ack,
  output logic          retire,
  output rv_pkg::word_t retire_pc,
  output logic          fault
);

  rv_pkg::word_t      pc;
  rv_pkg::word_t      pc_plus4;
  rv_pkg::word_t      pc_next;
  rv_pkg::word_t      ir;
  rv_pkg::word_t      ld_data;
  rv_pkg::word_t      imm;
  rv_pkg::word_t      rd1;
  rv_pkg::word_t      rd2;
  rv_pkg::word_t      op_a;
  rv_pkg::word_t      op_b;
  rv_pkg::word_t      alu_y;
  rv_pkg::word_t      wb_data;
  rv_pkg::reg_addr_t  ra1;
  rv_pkg::cu_state_e  state;
  rv_pkg::alu_a_e     alu_a;
  rv_pkg::alu_b_e     alu_b;
  rv_pkg::alu_op_e    alu_op;
  rv_pkg::imm_fmt_e   imm_fmt;
  rv_pkg::wb_src_e    wb_src;
  rv_pkg::pc_src_e    pc_src;
  logic               cmp_invert;
  logic               taken;
  logic               mem_req;
  logic               mem_we;
  logic               mem_ack;
  logic               load_ir;

  rv_control u_control (
    .clk(clk), .rst(rst), .opcode(ir[6:0]), .f3(ir[14:12]), .f7(ir[31:25]),
    .mem_ack(mem_ack), .hold(hold), .state(state), .alu_a(alu_a), .alu_b(alu_b),
    .alu_op(alu_op), .cmp_invert(cmp_invert), .imm_fmt(imm_fmt), .wb_src(wb_src),
    .pc_src(pc_src), .mem_req(mem_req), .mem_we(mem_we), .load_ir(load_ir),
    .retire(retire), .fault(fault)
  );

  // lui adds its immediate to x0
  assign ra1 = (imm_fmt == rv_pkg::IMM_U) ? '0 : ir[19:15];

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .ra1(ra1), .ra2(ir[24:20]), .rd1(rd1), .rd2(rd2),
    .we(retire && wb_src != rv_pkg::WB_NONE), .wa(ir[11:7]), .wd(wb_data)
  );

  always_comb begin
    case (imm_fmt)
      rv_pkg::IMM_S: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      rv_pkg::IMM_B: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      rv_pkg::IMM_U: imm = {ir[31:12], 12'b0};
      rv_pkg::IMM_J: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      default:       imm = {{20{ir[31]}}, ir[31:20]};
    endcase
  end

  assign op_a = (alu_a == rv_pkg::A_PC) ? pc : rd1;
  assign op_b = (alu_b == rv_pkg::B_IMM) ? imm : rd2;

  rv_alu u_alu (.op(alu_op), .a(op_a), .b(op_b), .y(alu_y));

  assign taken    = alu_y[0] ^ cmp_invert;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (pc_src)
      rv_pkg::PC_ALU:    pc_next = {alu_y[31:1], 1'b0};  // jalr clears bit 0
      rv_pkg::PC_BRANCH: pc_next = taken ? pc + imm : pc_plus4;
      default:           pc_next = pc_plus4;
    endcase
    case (wb_src)
      rv_pkg::WB_MEM:      wb_data = ld_data;
      rv_pkg::WB_PC_PLUS4: wb_data = pc_plus4;
      default:             wb_data = alu_y;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) pc <= '0;
    else if (retire) pc <= pc_next;
  end

  always_ff @(posedge clk) begin
    if (load_ir) ir <= ibus_dat_r;
    if (dbus_ack) ld_data <= dbus_dat_r;
  end

  // one request line, steered by the state
  assign mem_ack = (state == rv_pkg::CU_FETCH) ? ibus_ack : dbus_ack;

  assign ibus_cyc   = mem_req && state == rv_pkg::CU_FETCH;
  assign ibus_stb   = ibus_cyc;
  assign ibus_adr   = pc;
  assign dbus_cyc   = mem_req && state == rv_pkg::CU_EXEC;
  assign dbus_stb   = dbus_cyc;
  assign dbus_we    = mem_we;
  assign dbus_adr   = alu_y;
  assign dbus_dat_w = rd2;
  assign retire_pc  = pc;

endmodule

/* hw/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter #(
  parameter int ADDR_W = 10
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          ext_cyc,
  input  logic          ext_stb,
  input  logic          ext_we,
  input  rv_pkg::word_t ext_adr,
  input  rv_pkg::word_t ext_dat_w,
  output rv_pkg::word_t ext_dat_r,
  output logic          ext_ack,
  input  logic          dbus_cyc,
  input  logic          dbus_stb,
  input  logic          dbus_we,
  input  rv_pkg::word_t dbus_adr,
  input  rv_pkg::word_t dbus_dat_w,
  output rv_pkg::word_t dbus_dat_r,
  output logic          dbus_ack,
  input  logic          ibus_cyc,
  input  logic          ibus_stb,
  input  rv_pkg::word_t ibus_adr,
  output rv_pkg::word_t ibus_dat_r,
  output logic          ibus_ack,
  output logic          m_cyc,
  output logic          m_stb,
  output logic          m_we,
  output rv_pkg::word_t m_adr,
  output rv_pkg::word_t m_dat_w,
  input  rv_pkg::word_t m_dat_r,
  input  logic          m_ack
);

  typedef enum logic [1:0] {OWN_NONE, OWN_EXT, OWN_DBUS, OWN_IBUS} owner_e;

  owner_e        owner;
  logic          own_cyc;
  logic          own_stb;
  rv_pkg::word_t own_adr;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      owner <= OWN_NONE;
    end else if (owner == OWN_NONE) begin
      if (ext_cyc) owner <= OWN_EXT;            // fixed priority
      else if (dbus_cyc) owner <= OWN_DBUS;
      else if (ibus_cyc) owner <= OWN_IBUS;
    end else if (m_ack || !own_cyc) begin
      owner <= OWN_NONE;
    end
  end

  always_comb begin
    own_cyc = 1'b0;
    own_stb = 1'b0;
    m_we    = 1'b0;
    own_adr = '0;
    m_dat_w = '0;
    case (owner)
      OWN_EXT: begin
        own_cyc = ext_cyc;
        own_stb = ext_stb;
        m_we    = ext_we;
        own_adr = ext_adr;
        m_dat_w = ext_dat_w;
      end
      OWN_DBUS: begin
        own_cyc = dbus_cyc;
        own_stb = dbus_stb;
        m_we    = dbus_we;
        own_adr = dbus_adr;
        m_dat_w = dbus_dat_w;
      end
      OWN_IBUS: begin
        own_cyc = ibus_cyc;
        own_stb = ibus_stb;
        own_adr = ibus_adr;
      end
      default: ;
    endcase
  end

  assign m_cyc = own_cyc;
  assign m_stb = own_cyc && own_stb;
  assign m_adr = {{(32 - ADDR_W - 2){1'b0}}, own_adr[ADDR_W+1:0]};

  assign ext_ack  = (owner == OWN_EXT) && m_ack;
  assign dbus_ack = (owner == OWN_DBUS) && m_ack;
  assign ibus_ack = (owner == OWN_IBUS) && m_ack;

  assign ext_dat_r  = m_dat_r;
  assign dbus_dat_r = m_dat_r;
  assign ibus_dat_r = m_dat_r;

endmodule

/* hw/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
  parameter int ADDR_W = 10
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          cyc,
  input  logic          stb,
  input  logic          we,
  input  rv_pkg::word_t adr,
  input  rv_pkg::word_t dat_w,
  output rv_pkg::word_t dat_r,
  output logic          ack
);

  rv_pkg::word_t     mem [2**ADDR_W];
  logic [ADDR_W-1:0] idx;
  logic              start;

  assign idx   = adr[ADDR_W+1:2];  // word index
  assign start = cyc && stb && !ack;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) ack <= 1'b0;
    else ack <= start;  // one wait state
  end

  always_ff @(posedge clk) begin
    if (start) begin
      if (we) mem[idx] <= dat_w;
      dat_r <= mem[idx];
    end
  end

endmodule

/* hw/rv_soc.sv */
`timescale 1ns/1ps

module rv_soc #(
  parameter int ADDR_W = 10
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          hold,
  input  logic          ext_cyc,
  input  logic          ext_stb,
  input  logic          ext_we,
  input  rv_pkg::word_t ext_adr,
  input  rv_pkg::word_t ext_dat_w,
  output rv_pkg::word_t ext_dat_r,
  output logic          ext_ack,
  output logic          retire,
  output rv_pkg::word_t retire_pc,
  output logic          fault
);

  logic          ibus_cyc, ibus_stb, ibus_ack;
  rv_pkg::word_t ibus_adr, ibus_dat_r;
  logic          dbus_cyc, dbus_stb, dbus_we, dbus_ack;
  rv_pkg::word_t dbus_adr, dbus_dat_w, dbus_dat_r;
  logic          m_cyc, m_stb, m_we, m_ack;
  rv_pkg::word_t m_adr, m_dat_w, m_dat_r;

  rv_core u_core (
    .clk(clk), .rst(rst), .hold(hold),
    .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
    .ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
    .dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we), .dbus_adr(dbus_adr),
    .dbus_dat_w(dbus_dat_w), .dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack),
    .retire(retire), .retire_pc(retire_pc), .fault(fault)
  );

  wb_arbiter #(.ADDR_W(ADDR_W)) u_arbiter (
    .clk(clk), .rst(rst),
    .ext_cyc(ext_cyc), .ext_stb(ext_stb), .ext_we(ext_we), .ext_adr(ext_adr),
    .ext_dat_w(ext_dat_w), .ext_dat_r(ext_dat_r), .ext_ack(ext_ack),
    .dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we), .dbus_adr(dbus_adr),
    .dbus_dat_w(dbus_dat_w), .dbus_dat_r(dbus_dat_r), .dbus_ack(dbus_ack),
    .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
    .ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
    .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we), .m_adr(m_adr),
    .m_dat_w(m_dat_w), .m_dat_r(m_dat_r), .m_ack(m_ack)
  );

  wb_ram #(.ADDR_W(ADDR_W)) u_ram (
    .clk(clk), .rst(rst), .cyc(m_cyc), .stb(m_stb), .we(m_we), .adr(m_adr),
    .dat_w(m_dat_w), .dat_r(m_dat_r), .ack(m_ack)
  );

endmodule

/* verif/rv_soc_sva.sv */
`timescale 1ns/1ps

module rv_soc_sva (
  input logic              clk,
  input logic              rst,
  input logic              ext_cyc,
  input logic              ext_stb,
  input logic              ext_ack,
  input logic              ibus_cyc,
  input logic              ibus_ack,
  input logic              dbus_cyc,
  input logic              dbus_ack,
  input logic              m_stb,
  input logic              m_ack,
  input rv_pkg::word_t     m_adr,
  input logic              fault,
  input rv_pkg::cu_state_e cu_state
);

  int fail_count = 0;  // assertion failures so far

  stb_within_cyc: assert property (@(posedge clk) disable iff (!rst) !ext_stb || ext_cyc)
    else begin
      fail_count++;
      $error("ext stb high without cyc");
    end

  adr_held: assert property (@(posedge clk) disable iff (!rst)
    (m_stb && !m_ack) |=> (m_stb && $stable(m_adr)))
    else begin
      fail_count++;
      $error("ram address moved while waiting for ack");
    end

  ibus_drop_after_ack: assert property (@(posedge clk) disable iff (!rst)
    ibus_ack |=> !ibus_cyc)
    else begin
      fail_count++;
      $error("ibus cyc still high in the cycle after ack");
    end

  dbus_drop_after_ack: assert property (@(posedge clk) disable iff (!rst)
    dbus_ack |=> !dbus_cyc)
    else begin
      fail_count++;
      $error("dbus cyc still high in the cycle after ack");
    end

  ack_to_active_master: assert property (@(posedge clk) disable iff (!rst)
    (!ext_ack || ext_cyc) && (!dbus_ack || dbus_cyc) && (!ibus_ack || ibus_cyc))
    else begin
      fail_count++;
      $error("ack routed to a master without an open cycle");
    end

  fault_parks: assert property (@(posedge clk) disable iff (!rst)
    fault |-> (cu_state == rv_pkg::CU_EXEC && !ibus_cyc && !dbus_cyc))
    else begin
      fail_count++;
      $error("core left EXEC or used the bus after a fault");
    end

endmodule

bind rv_soc rv_soc_sva u_sva (.*, .cu_state(u_core.state));

/* verif/tb_rv_soc.sv */
`timescale 1ns/1ps

module tb_rv_soc;

  localparam int ADDR_W   = 10;
  localparam int N_RAND   = 40;           // random part of the program
  localparam int PROG_LEN = N_RAND + 32;  // then 31 dump stores and the self-loop
  localparam int DATA_N   = 16;
  localparam int N_CONT   = 4;
  localparam int EXT_OPS  = 2 * PROG_LEN + 2 * DATA_N + 3 * N_CONT + 31 + 1;
  localparam rv_pkg::word_t DATA_BASE    = 32'h400;
  localparam rv_pkg::word_t DUMP_BASE    = 32'h600;
  localparam rv_pkg::word_t SCRATCH_BASE = 32'h800;

  logic          clk = 1'b0;
  logic          rst;
  logic          hold;
  logic          ext_cyc;
  logic          ext_stb;
  logic          ext_we;
  rv_pkg::word_t ext_adr;
  rv_pkg::word_t ext_dat_w;
  rv_pkg::word_t ext_dat_r;
  logic          ext_ack;
  logic          retire;
  rv_pkg::word_t retire_pc;
  logic          fault;

  rv_pkg::word_t seed = 32'ha547b212;
  rv_pkg::word_t prog [PROG_LEN];
  rv_pkg::word_t data_init [DATA_N];
  rv_pkg::word_t mdl_mem [2**ADDR_W];
  rv_pkg::word_t mdl_regs [32];
  rv_pkg::word_t exp_pcs [$];
  rv_pkg::word_t loop_pc;
  logic          allow_loop = 1'b1;  // self-loop may keep retiring
  int            n_exp;
  int            retired = 0;
  int            cycles = 0;
  int            cycle_limit;

  rv_soc #(.ADDR_W(ADDR_W)) dut0 (
    .clk(clk), .rst(rst), .hold(hold),
    .ext_cyc(ext_cyc), .ext_stb(ext_stb), .ext_we(ext_we), .ext_adr(ext_adr),
    .ext_dat_w(ext_dat_w), .ext_dat_r(ext_dat_r), .ext_ack(ext_ack),
    .retire(retire), .retire_pc(retire_pc), .fault(fault)
  );

  always #50 clk = ~clk;

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t act, input rv_pkg::word_t exp);
    if (act !== exp)
      fail_stop($sformatf("FAIL time=%0t %s actual=%h expected=%h", $time, name, act, exp));
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
      fail_stop($sformatf("FAIL time=%0t %s actual=%b expected=%b", $time, name, act, exp));
  endtask

  function automatic rv_pkg::word_t rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    rv_pkg::word_t r;
    r = rand_word();
    return int'(r[30:16]) % n;  // upper bits since the low ones repeat quickly
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_ALU};
  endfunction

  function automatic rv_pkg::word_t enc_i(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_s(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], rv_pkg::OP_STORE};  // sw only
  endfunction

  function automatic rv_pkg::word_t enc_b(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t enc_j(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  function automatic void build_program();
    rv_pkg::word_t     w;
    rv_pkg::word_t     r;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic [2:0]        f3;
    logic [6:0]        f7;
    int                t;
    int                off;
    for (int i = 0; i < N_RAND; i++) begin
      r   = rand_word();
      rd  = r[31:27];
      rs1 = r[26:22];
      rs2 = r[21:17];
      f3  = r[16:14];
      f7  = (r[13] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      t   = i + 1 + rand_below(N_RAND - i);  // forward target up to the first dump store
      off = (t - i) * 4;
      case (rand_below(12))
        0, 1, 2: w = enc_r(f7, rs2, rs1, f3, rd);
        3, 4: begin
          w = rand_word();
          if (f3 == 3'd1 || f3 == 3'd5) w = {20'b0, f7, w[31:27]};  // shamt plus the srai bit
          w = enc_i(w, rs1, f3, rd, rv_pkg::OP_ALUI);
        end
        5: begin
          w = rand_word();
          w = {w[31:12], rd, rv_pkg::OP_LUI};
        end
        6: begin
          w = rand_word();
          w = {w[31:12], rd, rv_pkg::OP_AUIPC};
        end
        7, 8: begin
          if (r[12]) rs2 = rs1;  // equal operands give more taken branches
          if (f3[2:1] == 2'b01) f3 = {2'b00, f3[0]};
          w = enc_b(off, rs2, rs1, f3);
        end
        9: w = r[12] ? enc_j(off, rd) : enc_i(t * 4, 5'd0, 3'd0, rd, rv_pkg::OP_JALR);
        10: w = enc_i(DATA_BASE + 4 * rand_below(DATA_N), 5'd0, 3'd2, rd, rv_pkg::OP_LOAD);
        default: w = enc_s(DATA_BASE + 4 * rand_below(DATA_N), rs2, 5'd0);
      endcase
      prog[i] = w;
    end
    for (int x = 1; x < 32; x++)
      prog[N_RAND + x - 1] = enc_s(DUMP_BASE + 4 * (x - 1), rv_pkg::reg_addr_t'(x), 5'd0);
    prog[PROG_LEN - 1] = enc_j(32'd0, 5'd0);  // jal x0, 0
    for (int i = 0; i < 2**ADDR_W; i++) mdl_mem[i] = '0;
    for (int i = 0; i < PROG_LEN; i++) mdl_mem[i] = prog[i];
    for (int i = 0; i < DATA_N; i++) begin
      data_init[i] = rand_word();
      mdl_mem[int'(DATA_BASE >> 2) + i] = data_init[i];
    end
  endfunction

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
      input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a,
      input rv_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // instruction-set model that runs the program up to the self-loop
  function automatic void run_model();
    rv_pkg::word_t pc;
    rv_pkg::word_t nxt;
    rv_pkg::word_t ins;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t ea;
    rv_pkg::word_t res;
    logic          wr;
    logic          done;
    pc   = '0;
    done = 1'b0;
    res  = '0;
    for (int i = 0; i < 32; i++) mdl_regs[i] = '0;
    while (!done) begin
      ins   = mdl_mem[pc[ADDR_W+1:2]];
      exp_pcs.push_back(pc);
      a     = mdl_regs[ins[19:15]];
      b     = mdl_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      nxt   = pc + 32'd4;
      wr    = 1'b1;
      case (ins[6:0])
        rv_pkg::OP_ALU:   res = alu_ref(ins[14:12], ins[30], a, b);
        rv_pkg::OP_ALUI:  res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        rv_pkg::OP_LUI:   res = {ins[31:12], 12'b0};
        rv_pkg::OP_AUIPC: res = pc + {ins[31:12], 12'b0};
        rv_pkg::OP_JAL: begin
          res = pc + 32'd4;
          nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        rv_pkg::OP_JALR: begin
          res = pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end
        rv_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if (branch_ref(ins[14:12], a, b))
            nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        rv_pkg::OP_LOAD: begin
          ea  = a + imm_i;
          res = mdl_mem[ea[ADDR_W+1:2]];
        end
        default: begin  // sw is the only other generated opcode
          wr = 1'b0;
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          mdl_mem[ea[ADDR_W+1:2]] = b;
        end
      endcase
      if (wr && ins[11:7] != 5'd0) mdl_regs[ins[11:7]] = res;
      done = (nxt == pc);
      pc   = nxt;
    end
    loop_pc = pc;
  endfunction

  task automatic ext_cycle(input logic w, input rv_pkg::word_t a, input rv_pkg::word_t d,
      output rv_pkg::word_t q);
    @(posedge clk);
    ext_cyc   <= 1'b1;
    ext_stb   <= 1'b1;
    ext_we    <= w;
    ext_adr   <= a;
    ext_dat_w <= d;
    @(negedge clk);
    while (!ext_ack) @(negedge clk);
    q = ext_dat_r;
    @(posedge clk);
    ext_cyc <= 1'b0;  // drop in the cycle after ack
    ext_stb <= 1'b0;
    ext_we  <= 1'b0;
  endtask

  task automatic ext_write(input rv_pkg::word_t a, input rv_pkg::word_t d);
    rv_pkg::word_t q;
    ext_cycle(1'b1, a, d, q);
  endtask

  task automatic ext_read_check(input rv_pkg::word_t a, input rv_pkg::word_t exp,
      input string name);
    rv_pkg::word_t q;
    ext_cycle(1'b0, a, '0, q);
    check_word(name, q, exp);
  endtask

  always @(negedge clk) begin
    if (rst && retire) begin
      retired++;
      if (exp_pcs.size() > 0) check_word("retire_pc", retire_pc, exp_pcs.pop_front());
      else if (allow_loop) check_word("retire_pc", retire_pc, loop_pc);
      else fail_stop($sformatf("retire pulse at pc %h where none was expected", retire_pc));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit)
      fail_stop($sformatf("simulation ran past %0d cycles without finishing", cycle_limit));
  end

  always @(dut0.u_sva.fail_count) begin
    if (dut0.u_sva.fail_count != 0)
      fail_stop($sformatf("%0d bus or FSM assertion failures", dut0.u_sva.fail_count));
  end

  initial begin
    rv_pkg::word_t q;
    int            j;
    rst       = 1'b0;
    hold      = 1'b1;
    ext_cyc   = 1'b0;
    ext_stb   = 1'b0;
    ext_we    = 1'b0;
    ext_adr   = '0;
    ext_dat_w = '0;
    build_program();
    run_model();
    n_exp       = exp_pcs.size();
    cycle_limit = 40 * (n_exp + 4) + 12 * EXT_OPS + 200;
    repeat (4) @(posedge clk);
    rst <= 1'b1;

    for (int i = 0; i < PROG_LEN; i++) ext_write(4 * i, prog[i]);
    for (int i = 0; i < DATA_N; i++) ext_write(DATA_BASE + 4 * i, data_init[i]);
    for (int i = 0; i < PROG_LEN; i++) ext_read_check(4 * i, prog[i], "ext_dat_r program");
    @(posedge clk);
    hold <= 1'b0;

    // ext traffic while the core competes for the RAM
    for (int i = 0; i < N_CONT; i++) begin
      q = rand_word();
      j = rand_below(PROG_LEN);
      ext_write(SCRATCH_BASE + 4 * i, q);
      ext_read_check(SCRATCH_BASE + 4 * i, q, "ext_dat_r scratch");
      ext_read_check(4 * j, prog[j], "ext_dat_r program");
    end
    while (retired < n_exp) @(posedge clk);
    hold <= 1'b1;
    @(negedge clk);
    check_bit("fault", fault, 1'b0);
    for (int x = 1; x < 32; x++)
      ext_read_check(DUMP_BASE + 4 * (x - 1), mdl_regs[x], $sformatf("ext_dat_r dump x%0d", x));
    for (int i = 0; i < DATA_N; i++)
      ext_read_check(DATA_BASE + 4 * i, mdl_mem[int'(DATA_BASE >> 2) + i],
                     $sformatf("ext_dat_r data word %0d", i));

    // second run with an illegal opcode at address 0
    @(posedge clk);
    rst  <= 1'b0;
    hold <= 1'b1;
    repeat (4) @(posedge clk);
    allow_loop = 1'b0;
    rst <= 1'b1;
    q = rand_word();
    ext_write(32'd0, q | 32'h7f);
    @(posedge clk);
    hold <= 1'b0;
    @(negedge clk);
    while (!fault) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      check_bit("m_cyc", dut0.m_cyc, 1'b0);
      check_bit("retire", retire, 1'b0);
      check_bit("fault", fault, 1'b1);
    end

    if (dut0.u_sva.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      fail_stop($sformatf("%0d bus or FSM assertion failures", dut0.u_sva.fail_count));
    end
  end

endmodule

/* tb.f */
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_control.sv
hw/rv_core.sv
hw/wb_arbiter.sv
hw/wb_ram.sv
hw/rv_soc.sv
verif/rv_soc_sva.sv
verif/tb_rv_soc.sv
